// File: hw/glay_consts.svh
`ifndef GLAY_CONSTS_SVH
`define GLAY_CONSTS_SVH

// Vertex index width, 256 vertices per table
`define GLAY_VERTEX_W 8

// Out-degree of one vertex
`define GLAY_DEGREE_W 16

// Edge offsets and edge totals
`define GLAY_OFFSET_W 32

// Entries per vertex table, one per vertex id
`define GLAY_TABLE_DEPTH 256

`endif

// File: hw/glay_pkg.sv
`include "glay_consts.svh"

package glay_pkg;

    // -------------------------------------------------------------------------
    // Graph payload types
    // -------------------------------------------------------------------------

    // Vertex index, also the table address
    typedef logic [`GLAY_VERTEX_W-1:0] vertex_id_t;

    // Per-vertex out-degree
    typedef logic [`GLAY_DEGREE_W-1:0] degree_t;

    // CSR edge offset or edge count
    typedef logic [`GLAY_OFFSET_W-1:0] offset_t;

    // -------------------------------------------------------------------------
    // ap_ctrl_hs sequencing
    // -------------------------------------------------------------------------

    // Kernel control FSM states
    typedef enum logic [2:0] {
        CTRL_RESET,
        CTRL_IDLE,
        CTRL_SETUP,
        // Start accepted, waiting for the engine to be free
        CTRL_READY,
        // One-cycle request launch
        CTRL_START,
        CTRL_BUSY,
        // Held until the host starts again
        CTRL_DONE
    } ctrl_state_t;

endpackage : glay_pkg

// File: hw/vertex_memory.sv
`include "glay_consts.svh"

module vertex_memory #(
    parameter type entry_t = glay_pkg::offset_t,
    parameter int  depth   = `GLAY_TABLE_DEPTH
) (
    input  logic                 ap_clk,
    input  logic                 wr_en,
    input  glay_pkg::vertex_id_t wr_addr,
    input  entry_t               wr_data,
    input  glay_pkg::vertex_id_t rd_addr,
    output entry_t               rd_data
);

    // Register array, one entry per vertex
    entry_t entries [depth];

    // Write lands on the clock edge
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            entries[wr_addr] <= wr_data;
        end
    end

    // Registered read, one cycle of latency
    // Read of the address being written returns the old entry
    always_ff @(posedge ap_clk) begin
        rd_data <= entries[rd_addr];
    end

endmodule : vertex_memory

// File: hw/kernel_control.sv
module kernel_control (
    input  logic                 ap_clk,
    input  logic                 areset_control,
    input  logic                 ap_start,
    output logic                 ap_ready,
    output logic                 ap_done,
    output logic                 ap_idle,
    input  glay_pkg::vertex_id_t desc_vertex_start,
    input  glay_pkg::vertex_id_t desc_vertex_count,
    input  glay_pkg::offset_t    desc_offset_base,
    input  logic [7:0]           desc_flags,
    input  logic                 cu_setup,
    input  logic                 cu_done,
    output logic                 cu_start,
    output logic                 descriptor_valid,
    output glay_pkg::vertex_id_t vertex_start,
    output glay_pkg::vertex_id_t vertex_count,
    output glay_pkg::offset_t    offset_base,
    output logic                 endian
);
    import glay_pkg::*;

    // Registered handshake inputs
    logic ap_start_reg;
    logic cu_setup_reg;
    logic cu_done_reg;

    // First descriptor stage
    vertex_id_t vertex_start_reg;
    vertex_id_t vertex_count_reg;
    offset_t    offset_base_reg;
    logic       endian_flag_reg;

    // First output stage, decoded from the state
    logic ready_s1;
    logic done_s1;
    logic idle_s1;
    logic start_s1;
    logic valid_s1;
    logic endian_s1;

    ctrl_state_t state;
    ctrl_state_t next_state;

    // -------------------------------------------------------------------------
    // Input registers
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_start_reg <= 1'b0;
            cu_setup_reg <= 1'b0;
            cu_done_reg  <= 1'b0;
        end else begin
            ap_start_reg <= ap_start;
            cu_setup_reg <= cu_setup;
            cu_done_reg  <= cu_done;
        end
    end

    // Descriptor pipeline, two stages
    // Host keeps it stable while ap_start is high
    always_ff @(posedge ap_clk) begin
        vertex_start_reg <= desc_vertex_start;
        vertex_count_reg <= desc_vertex_count;
        offset_base_reg  <= desc_offset_base;
        endian_flag_reg  <= desc_flags[0];
        vertex_start     <= vertex_start_reg;
        vertex_count     <= vertex_count_reg;
        offset_base      <= offset_base_reg;
    end

    // -------------------------------------------------------------------------
    // ap_ctrl_hs FSM
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            state <= CTRL_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            CTRL_RESET: next_state = CTRL_IDLE;
            CTRL_IDLE:  next_state = CTRL_SETUP;
            // Wait for the host
            CTRL_SETUP: if (ap_start_reg) next_state = CTRL_READY;
            // Wait for an idle engine
            CTRL_READY: if (cu_setup_reg) next_state = CTRL_START;
            CTRL_START: next_state = CTRL_BUSY;
            // Engine ack ends the run
            CTRL_BUSY:  if (cu_done_reg) next_state = CTRL_DONE;
            // Back-to-back runs restart from here
            CTRL_DONE:  if (ap_start_reg) next_state = CTRL_READY;
            default:    next_state = CTRL_RESET;
        endcase
    end

    // State decode into the first output stage
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ready_s1  <= 1'b0;
            done_s1   <= 1'b0;
            idle_s1   <= 1'b1;
            start_s1  <= 1'b0;
            valid_s1  <= 1'b0;
            endian_s1 <= 1'b0;
        end else begin
            ready_s1  <= (state == CTRL_READY);
            done_s1   <= (state == CTRL_DONE);
            idle_s1   <= (state == CTRL_RESET) || (state == CTRL_IDLE) ||
                         (state == CTRL_SETUP) || (state == CTRL_DONE);
            // Request held through START and BUSY, dropped in DONE
            start_s1  <= (state == CTRL_START) || (state == CTRL_BUSY);
            valid_s1  <= (state == CTRL_START) || (state == CTRL_BUSY);
            endian_s1 <= ((state == CTRL_START) || (state == CTRL_BUSY)) && endian_flag_reg;
        end
    end

    // -------------------------------------------------------------------------
    // Second output stage
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_ready         <= 1'b0;
            ap_done          <= 1'b0;
            ap_idle          <= 1'b1;
            cu_start         <= 1'b0;
            descriptor_valid <= 1'b0;
            endian           <= 1'b0;
        end else begin
            ap_ready         <= ready_s1;
            ap_done          <= done_s1;
            ap_idle          <= idle_s1;
            cu_start         <= start_s1;
            descriptor_valid <= valid_s1;
            endian           <= endian_s1;
        end
    end

endmodule : kernel_control

// File: hw/degree_engine.sv
`include "glay_consts.svh"

module degree_engine (
    input  logic                 ap_clk,
    input  logic                 areset_control,
    input  logic                 cu_start,
    output logic                 cu_setup,
    output logic                 cu_done,
    input  glay_pkg::vertex_id_t vertex_start,
    input  glay_pkg::vertex_id_t vertex_count,
    input  glay_pkg::offset_t    offset_base,
    input  logic                 endian,
    output glay_pkg::vertex_id_t deg_rd_addr,
    input  glay_pkg::degree_t    deg_rd_data,
    output logic                 offset_wr_en,
    output glay_pkg::vertex_id_t offset_wr_addr,
    output glay_pkg::offset_t    offset_wr_data,
    output glay_pkg::offset_t    total_edges
);
    import glay_pkg::*;

    typedef enum logic [1:0] {ENG_IDLE, ENG_READ, ENG_WRITE, ENG_DONE} eng_state_t;

    eng_state_t state;
    vertex_id_t index;
    vertex_id_t cur_addr;
    // Request captured at accept
    vertex_id_t start_q;
    vertex_id_t count_q;
    offset_t    base_q;
    logic       endian_q;
    offset_t    running_sum;
    offset_t    next_sum;
    logic       accept;
    logic       last_vertex;

    // Reverse byte order of an offset
    function automatic offset_t byte_swap(input offset_t value);
        offset_t swapped;
        for (int i = 0; i < `GLAY_OFFSET_W / 8; i++) begin
            swapped[i*8 +: 8] = value[`GLAY_OFFSET_W - 8 - i*8 +: 8];
        end
        return swapped;
    endfunction

    // New request only with ack low
    assign accept      = (state == ENG_IDLE) && cu_start && !cu_done;
    // 8-bit sum wraps modulo the table depth
    assign cur_addr    = start_q + index;
    assign next_sum    = running_sum + offset_t'(deg_rd_data);
    assign last_vertex = (index == count_q - 1'b1);

    // -------------------------------------------------------------------------
    // Sequencer, one read cycle and one write cycle per vertex
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            state       <= ENG_IDLE;
            index       <= '0;
            total_edges <= '0;
        end else begin
            case (state)
                ENG_IDLE: if (accept) begin
                    index <= '0;
                    // Empty range finishes at once
                    if (vertex_count == '0) begin
                        total_edges <= '0;
                        state       <= ENG_DONE;
                    end else begin
                        state <= ENG_READ;
                    end
                end
                ENG_READ: state <= ENG_WRITE;
                ENG_WRITE: begin
                    index <= index + 1'b1;
                    if (last_vertex) begin
                        // Edge count excludes the base, never swapped
                        total_edges <= next_sum - base_q;
                        state       <= ENG_DONE;
                    end else begin
                        state <= ENG_READ;
                    end
                end
                // Ack holds until req falls
                ENG_DONE: if (!cu_start) state <= ENG_IDLE;
                default:  state <= ENG_IDLE;
            endcase
        end
    end

    // Descriptor latch and running sum
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            start_q     <= vertex_start;
            count_q     <= vertex_count;
            base_q      <= offset_base;
            endian_q    <= endian;
            running_sum <= offset_base;
        end else if (state == ENG_WRITE) begin
            running_sum <= next_sum;
        end
    end

    // Degree arrives in WRITE, one cycle after the READ address
    assign deg_rd_addr    = cur_addr;
    assign offset_wr_en   = (state == ENG_WRITE);
    assign offset_wr_addr = cur_addr;
    // Exclusive prefix, written before this vertex's degree is added
    assign offset_wr_data = endian_q ? byte_swap(running_sum) : running_sum;

    assign cu_setup = (state == ENG_IDLE) && !cu_done;
    assign cu_done  = (state == ENG_DONE);

endmodule : degree_engine

// File: hw/glay_kernel_top.sv
`include "glay_consts.svh"

module glay_kernel_top (
    input  logic                 ap_clk,
    input  logic                 areset_control,
    input  logic                 ap_start,
    output logic                 ap_ready,
    output logic                 ap_done,
    output logic                 ap_idle,
    input  glay_pkg::vertex_id_t desc_vertex_start,
    input  glay_pkg::vertex_id_t desc_vertex_count,
    input  glay_pkg::offset_t    desc_offset_base,
    input  logic [7:0]           desc_flags,
    input  logic                 deg_wr_en,
    input  glay_pkg::vertex_id_t deg_wr_addr,
    input  glay_pkg::degree_t    deg_wr_data,
    input  glay_pkg::vertex_id_t offset_rd_addr,
    output glay_pkg::offset_t    offset_rd_data,
    output glay_pkg::offset_t    total_edges
);
    import glay_pkg::*;

    // Control to engine request channel
    logic       cu_start;
    logic       cu_setup;
    logic       cu_done;
    logic       descriptor_valid;
    vertex_id_t vertex_start;
    vertex_id_t vertex_count;
    offset_t    offset_base;
    logic       endian;

    // Engine table ports
    vertex_id_t deg_rd_addr;
    degree_t    deg_rd_data;
    logic       offset_wr_en;
    vertex_id_t offset_wr_addr;
    offset_t    offset_wr_data;

    kernel_control u_kernel_control (
        .ap_clk, .areset_control, .ap_start, .ap_ready, .ap_done, .ap_idle,
        .desc_vertex_start, .desc_vertex_count, .desc_offset_base, .desc_flags,
        .cu_setup, .cu_done, .cu_start, .descriptor_valid,
        .vertex_start, .vertex_count, .offset_base, .endian
    );

    // Request only counts with a valid descriptor behind it
    degree_engine u_degree_engine (
        .ap_clk, .areset_control,
        .cu_start       (cu_start & descriptor_valid),
        .cu_setup, .cu_done, .vertex_start, .vertex_count, .offset_base, .endian,
        .deg_rd_addr, .deg_rd_data, .offset_wr_en, .offset_wr_addr, .offset_wr_data,
        .total_edges
    );

    // Degrees, loaded by the host side
    vertex_memory #(.entry_t(degree_t), .depth(`GLAY_TABLE_DEPTH)) degree_table (
        .ap_clk, .wr_en(deg_wr_en), .wr_addr(deg_wr_addr), .wr_data(deg_wr_data),
        .rd_addr(deg_rd_addr), .rd_data(deg_rd_data)
    );

    // CSR offsets, filled by the engine
    vertex_memory #(.entry_t(offset_t), .depth(`GLAY_TABLE_DEPTH)) offset_table (
        .ap_clk, .wr_en(offset_wr_en), .wr_addr(offset_wr_addr), .wr_data(offset_wr_data),
        .rd_addr(offset_rd_addr), .rd_data(offset_rd_data)
    );

endmodule : glay_kernel_top

// File: test/glay_kernel_tb.sv
`include "glay_consts.svh"

module glay_kernel_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import glay_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int DEPTH = `GLAY_TABLE_DEPTH;
    localparam int NUM_RUNS = 7;
    // Per run at most DEPTH vertices at 4 cycles each, plus table load and reset
    localparam int WATCHDOG_CYCLES = NUM_RUNS * DEPTH * 4 + 2 * DEPTH + 500;

    logic       ap_clk;
    logic       areset_control;
    logic       ap_start;
    logic       ap_ready;
    logic       ap_done;
    logic       ap_idle;
    vertex_id_t desc_vertex_start;
    vertex_id_t desc_vertex_count;
    offset_t    desc_offset_base;
    logic [7:0] desc_flags;
    logic       deg_wr_en;
    vertex_id_t deg_wr_addr;
    degree_t    deg_wr_data;
    vertex_id_t offset_rd_addr;
    offset_t    offset_rd_data;
    offset_t    total_edges;

    // Reference copy of the degree table and expected results
    degree_t deg_model [DEPTH];
    offset_t exp_offset [DEPTH];
    offset_t exp_total;
    // Set with the first ap_start
    logic    started;

    glay_kernel_top uut (.*);

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    task automatic report_error(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopping at the first failed check");
    endtask

    // ---------------------------------------------------------------------------
    // Handshake checks
    // ---------------------------------------------------------------------------
    assert property (@(posedge ap_clk) disable iff (areset_control)
        !started |-> (ap_idle && !ap_ready && !ap_done))
        else report_error("kernel left idle before the first ap_start");
    assert property (@(posedge ap_clk) disable iff (areset_control) !(ap_ready && ap_done))
        else report_error("ap_ready and ap_done high together");
    assert property (@(posedge ap_clk) disable iff (areset_control) ap_done |-> ap_idle)
        else report_error("ap_idle low while ap_done is high");
    // Done is sticky until the host starts again
    assert property (@(posedge ap_clk) disable iff (areset_control)
        (ap_done && !ap_start) |=> ap_done)
        else report_error("ap_done dropped without a new ap_start");

    function automatic offset_t swap_bytes(input offset_t v);
        return {v[7:0], v[15:8], v[23:16], v[31:24]};
    endfunction

    function automatic int pick_in_range(input int lo, input int hi);
        return lo + int'($urandom % 32'(hi - lo + 1));
    endfunction

    // Random degree for every vertex
    task automatic load_degrees();
        degree_t value;
        for (int a = 0; a < DEPTH; a++) begin
            value = degree_t'($urandom);
            @(posedge ap_clk);
            deg_wr_en   <= 1'b1;
            deg_wr_addr <= vertex_id_t'(a);
            deg_wr_data <= value;
            deg_model[a] = value;
        end
        @(posedge ap_clk);
        deg_wr_en <= 1'b0;
    endtask

    // Exclusive prefix sum over the range, address wraps at the table end
    task automatic compute_expected(input vertex_id_t start, input vertex_id_t count,
                                    input offset_t base, input logic swap);
        offset_t    sum;
        vertex_id_t addr;
        int         n;
        sum = '0;
        n = int'(count);
        for (int i = 0; i < n; i++) begin
            addr = vertex_id_t'(int'(start) + i);
            exp_offset[addr] = swap ? swap_bytes(base + sum) : base + sum;
            sum = sum + offset_t'(deg_model[addr]);
        end
        exp_total = sum;
    endtask

    // Pipelined readback, one address per cycle
    task automatic check_offsets(input vertex_id_t start, input vertex_id_t count);
        vertex_id_t addr;
        vertex_id_t prev_addr;
        int         n;
        n = int'(count);
        addr = start;
        prev_addr = start;
        for (int i = 0; i <= n; i++) begin
            @(posedge ap_clk);
            if (i < n) begin
                addr = vertex_id_t'(int'(start) + i);
                offset_rd_addr <= addr;
            end
            @(negedge ap_clk);
            if (i > 0) begin
                assert (offset_rd_data == exp_offset[prev_addr])
                    else report_error($sformatf("offset entry %0d read %h, expected %h",
                        prev_addr, offset_rd_data, exp_offset[prev_addr]));
            end
            prev_addr = addr;
        end
    endtask

    // ---------------------------------------------------------------------------
    // One kernel run through ap_ctrl_hs
    // ---------------------------------------------------------------------------
    task automatic run_kernel(input vertex_id_t start, input vertex_id_t count,
                              input offset_t base, input logic swap);
        logic ready_seen;
        compute_expected(start, count, base, swap);
        @(posedge ap_clk);
        desc_vertex_start <= start;
        desc_vertex_count <= count;
        desc_offset_base  <= base;
        desc_flags        <= {7'b0, swap};
        ap_start          <= 1'b1;
        started           <= 1'b1;
        // Hold start until the kernel accepts it
        ready_seen = 1'b0;
        while (!ready_seen) begin
            @(negedge ap_clk);
            ready_seen = ap_ready;
        end
        assert (!ap_done) else report_error("ap_done high together with ap_ready");
        @(posedge ap_clk);
        ap_start <= 1'b0;
        // Stale done is gone by now, this is the new one
        do @(negedge ap_clk); while (!ap_done);
        assert (total_edges == exp_total)
            else report_error($sformatf("total_edges %h, expected %h", total_edges, exp_total));
        check_offsets(start, count);
        repeat (3) begin
            @(negedge ap_clk);
            assert (ap_done && ap_idle) else report_error("done state not held");
        end
    endtask

    task automatic random_run(input int start_lo, input int start_hi,
                              input int count_lo, input int count_hi, input logic swap);
        vertex_id_t start;
        vertex_id_t count;
        start = vertex_id_t'(pick_in_range(start_lo, start_hi));
        count = vertex_id_t'(pick_in_range(count_lo, count_hi));
        run_kernel(start, count, offset_t'($urandom), swap);
    endtask

    initial begin
        void'($urandom(32'h16fb15a7));
        areset_control    = 1'b1;
        ap_start          = 1'b0;
        desc_vertex_start = '0;
        desc_vertex_count = '0;
        desc_offset_base  = '0;
        desc_flags        = '0;
        deg_wr_en         = 1'b0;
        deg_wr_addr       = '0;
        deg_wr_data       = '0;
        offset_rd_addr    = '0;
        started           = 1'b0;
        repeat (2) @(posedge ap_clk);
        areset_control <= 1'b0;
        load_degrees();
        // Plain range, then byte-swapped
        random_run(0, 127, 1, 128, 1'b0);
        random_run(0, 127, 1, 128, 1'b1);
        // Range past the table end
        random_run(200, 255, 60, 200, 1'b0);
        // Empty range
        random_run(0, 255, 0, 0, 1'($urandom));
        // Back-to-back from DONE
        for (int r = 0; r < NUM_RUNS - 4; r++) begin
            random_run(0, 255, 1, 255, 1'($urandom));
        end
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        $display("timeout: kernel runs did not finish within %0d clock cycles",
                 WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule : glay_kernel_tb

// File: verilog.f
+incdir+hw
hw/glay_pkg.sv
hw/vertex_memory.sv
hw/kernel_control.sv
hw/degree_engine.sv
hw/glay_kernel_top.sv
test/glay_kernel_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := glay_kernel_tb
FILELIST  := verilog.f
VFLAGS    := --binary --assert --timescale 1ns/1ps -j 0
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
